/* source/bitsync_config.svh */
// Bit synchronizer configuration
// Datapath widths, APB register map and lock averaging length

`ifndef BITSYNC_CONFIG_SVH
`define BITSYNC_CONFIG_SVH

// Datapath widths
`define SAMPLE_WIDTH    18
`define FREQ_WIDTH      32
`define LOCK_WIDTH      16

// Crossings averaged per lock test
`define AVG_LENGTH      16

// APB register map
`define APB_ADDR_WIDTH  4
`define REG_CTRL        4'h0
`define REG_GAINS       4'h4
`define REG_LOCK        4'h8
`define REG_STATUS      4'hc

`endif

/* source/bitsyncPkg.sv */
// Bit synchronizer types
// Demod mode encoding and the packed structs shared by the datapath

`default_nettype none

`include "bitsync_config.svh"

package bitsyncPkg;

    typedef enum logic [1:0] {
        BPSK  = 2'd0,
        QPSK  = 2'd1,
        OQPSK = 2'd2
    } demodMode_t;

    // One baseband sample pair
    typedef struct packed {
        logic signed [`SAMPLE_WIDTH-1:0] i;
        logic signed [`SAMPLE_WIDTH-1:0] q;
    } iqSample_t;

    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } apbRequest_t;

    typedef struct packed {
        logic       useSummer;
        demodMode_t demodMode;
        logic [4:0] propShift;
        logic [4:0] intShift;
        logic [14:0] lockCount;
    } bitsyncConfig_t;

    // Crossing error of both rails plus the I magnitudes for lock
    typedef struct packed {
        logic signed [`SAMPLE_WIDTH:0]   error;
        logic [`SAMPLE_WIDTH-1:0]        offMag;
        logic [`SAMPLE_WIDTH-1:0]        onMag;
        logic                            transition;
    } timingError_t;

endpackage

`default_nettype wire

/* source/bitsyncControl.sv */
// Bit synchronizer control
// APB register file with zero wait states, and the half-symbol
// on-time/off-time phase state

`timescale 1ns/1ps
`default_nettype none

`include "bitsync_config.svh"

module bitsyncControl (
    input  logic                         sampleClk,
    input  logic                         reset,
    input  bitsyncPkg::apbRequest_t      apb,
    input  logic                         symTimes2Sync,
    input  logic                         bitsyncLock,
    input  logic [`LOCK_WIDTH-1:0]       lockCounter,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output bitsyncPkg::bitsyncConfig_t   cfg,
    output logic                         onTime
);

    logic writeEn;

    assign writeEn = apb.psel && apb.penable && apb.pwrite;
    assign pready  = 1'b1;

    // **************************************************
    // Register writes
    // **************************************************
    always_ff @(posedge sampleClk) begin
        if (reset) begin
            cfg.useSummer <= 1'b0;
            cfg.demodMode <= bitsyncPkg::BPSK;
            cfg.propShift <= 5'd4;
            cfg.intShift  <= 5'd0;
            cfg.lockCount <= 15'd3;
        end else if (writeEn) begin
            case (apb.paddr)
                `REG_CTRL: begin
                    cfg.useSummer <= apb.pwdata[0];
                    cfg.demodMode <= bitsyncPkg::demodMode_t'(apb.pwdata[2:1]);
                end
                `REG_GAINS: begin
                    cfg.propShift <= apb.pwdata[4:0];
                    cfg.intShift  <= apb.pwdata[12:8];
                end
                `REG_LOCK: cfg.lockCount <= apb.pwdata[14:0];
                // STATUS is read only
                default: ;
            endcase
        end
    end

    // Read mux
    always_comb begin
        case (apb.paddr)
            `REG_CTRL:   prdata = {29'd0, cfg.demodMode, cfg.useSummer};
            `REG_GAINS:  prdata = {19'd0, cfg.intShift, 3'd0, cfg.propShift};
            `REG_LOCK:   prdata = {17'd0, cfg.lockCount};
            `REG_STATUS: prdata = {15'd0, bitsyncLock, lockCounter};
            default:     prdata = 32'd0;
        endcase
    end

    // **************************************************
    // Half-symbol phase, on-time first after reset
    // **************************************************
    always_ff @(posedge sampleClk) begin
        if (reset) begin
            onTime <= 1'b1;
        end else if (symTimes2Sync) begin
            onTime <= ~onTime;
        end
    end

    // Master must hold psel through the access phase
    apbEnableNeedsSelect: assert property (
        @(posedge sampleClk) disable iff (reset) apb.penable |-> apb.psel
    );

endmodule

`default_nettype wire

/* source/matchedSummer.sv */
// Two-sample summing matched filter on I and Q
// Also delays Q by half a symbol for offset QPSK

`timescale 1ns/1ps
`default_nettype none

`include "bitsync_config.svh"

module matchedSummer (
    input  logic                         sampleClk,
    input  logic                         symTimes2Sync,
    input  bitsyncPkg::bitsyncConfig_t   cfg,
    input  bitsyncPkg::iqSample_t        rawIn,
    output bitsyncPkg::iqSample_t        mf
);

    localparam int SW = `SAMPLE_WIDTH;

    bitsyncPkg::iqSample_t delayed;
    bitsyncPkg::iqSample_t filtered;
    logic signed [SW-1:0]  qSkew;
    logic signed [SW:0]    iSum;
    logic signed [SW:0]    qSum;

    assign iSum = {delayed.i[SW-1], delayed.i} + {rawIn.i[SW-1], rawIn.i};
    assign qSum = {delayed.q[SW-1], delayed.q} + {rawIn.q[SW-1], rawIn.q};

    // Halved pairwise sum, or just the delayed sample
    always_comb begin
        if (cfg.useSummer) begin
            filtered.i = iSum[SW:1];
            filtered.q = qSum[SW:1];
        end else begin
            filtered = delayed;
        end
    end

    always_ff @(posedge sampleClk) begin
        if (symTimes2Sync) begin
            delayed <= rawIn;
            qSkew   <= filtered.q;
            mf.i    <= filtered.i;
            case (cfg.demodMode)
                bitsyncPkg::OQPSK: mf.q <= qSkew;
                // Single rail, both rails see I
                bitsyncPkg::BPSK:  mf.q <= filtered.i;
                default:           mf.q <= filtered.q;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/transitionDetector.sv */
// Early/on/late zero-crossing timing error detector
// Forms the timing and DC offset errors and recovers on-time data

`timescale 1ns/1ps
`default_nettype none

`include "bitsync_config.svh"

module transitionDetector (
    input  logic                          sampleClk,
    input  logic                          reset,
    input  logic                          symTimes2Sync,
    input  logic                          onTime,
    input  bitsyncPkg::iqSample_t         mf,
    output bitsyncPkg::timingError_t      ted,
    output logic                          errorValid,
    output logic signed [`SAMPLE_WIDTH-1:0] offsetError,
    output logic signed [`SAMPLE_WIDTH-1:0] bsError,
    output bitsyncPkg::iqSample_t         symData,
    output logic                          bitDataI,
    output logic                          bitDataQ
);

    localparam int SW = `SAMPLE_WIDTH;

    // Sample history, late is the newest
    bitsyncPkg::iqSample_t late;
    bitsyncPkg::iqSample_t off;
    bitsyncPkg::iqSample_t early;

    logic signed [SW-1:0] iError;
    logic signed [SW-1:0] qError;
    logic                 iCross;
    logic                 offStrobe;

    // Zero unless the early and late signs differ
    function automatic logic signed [SW-1:0] railError(
        input logic signed [SW-1:0] earlySample,
        input logic signed [SW-1:0] lateSample,
        input logic signed [SW-1:0] offSample
    );
        if (earlySample[SW-1] == lateSample[SW-1]) begin
            return '0;
        end
        return earlySample[SW-1] ? offSample : -offSample;
    endfunction

    function automatic logic [SW-1:0] magnitude(input logic signed [SW-1:0] x);
        return x[SW-1] ? -x : x;
    endfunction

    assign iCross    = early.i[SW-1] != late.i[SW-1];
    assign iError    = railError(early.i, late.i, off.i);
    assign qError    = railError(early.q, late.q, off.q);
    assign offStrobe = symTimes2Sync && !onTime;

    // **************************************************
    // History, errors and recovered data
    // **************************************************
    always_ff @(posedge sampleClk) begin
        if (symTimes2Sync) begin
            late  <= mf;
            off   <= late;
            early <= off;
        end
        if (symTimes2Sync && onTime) begin
            symData  <= off;
            bitDataI <= off.i[SW-1];
            bitDataQ <= off.q[SW-1];
        end
        if (offStrobe) begin
            ted.error      <= {iError[SW-1], iError} + {qError[SW-1], qError};
            ted.offMag     <= magnitude(iError);
            ted.onMag      <= magnitude(early.i);
            ted.transition <= iCross;
            offsetError    <= iCross ? off.i : '0;
        end
    end

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            errorValid <= 1'b0;
        end else begin
            errorValid <= offStrobe;
        end
    end

    // Halved with rounding
    assign bsError = ted.error[SW:1] + {{(SW-1){1'b0}}, ted.error[0]};

    // One error per symbol needs the phase to alternate
    errorValidSpacing: assert property (
        @(posedge sampleClk) disable iff (reset) errorValid |=> !errorValid
    );

endmodule

`default_nettype wire

/* source/loopFilter.sv */
// Proportional-integral loop filter
// Turns the timing error into the sample frequency word that steers
// the resampler

`timescale 1ns/1ps
`default_nettype none

`include "bitsync_config.svh"

module loopFilter (
    input  logic                          sampleClk,
    input  logic                          reset,
    input  logic                          errorValid,
    input  logic signed [`SAMPLE_WIDTH:0] error,
    input  logic [4:0]                    propShift,
    input  logic [4:0]                    intShift,
    output logic [`FREQ_WIDTH-1:0]        sampleFreq
);

    localparam int FW = `FREQ_WIDTH;

    logic signed [FW-1:0] integrator;
    logic signed [FW-1:0] errorExt;
    logic signed [FW-1:0] nextIntegrator;
    logic signed [FW-1:0] propTerm;

    // Sign extension into the frequency word
    assign errorExt       = error;
    assign nextIntegrator = integrator + (errorExt <<< intShift);
    assign propTerm       = errorExt <<< propShift;

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            integrator <= '0;
            sampleFreq <= '0;
        end else if (errorValid) begin
            integrator <= nextIntegrator;
            sampleFreq <= nextIntegrator + propTerm;
        end
    end

endmodule

`default_nettype wire

/* source/lockDetector.sv */
// Lock detector
// Averages crossing error against on-time magnitude over a block of
// crossings, then steps an up/down lock counter with hysteresis

`timescale 1ns/1ps
`default_nettype none

`include "bitsync_config.svh"

module lockDetector (
    input  logic                       sampleClk,
    input  logic                       reset,
    input  logic                       errorValid,
    input  bitsyncPkg::timingError_t   ted,
    input  logic [14:0]                lockCount,
    output logic                       bitsyncLock,
    output logic [`LOCK_WIDTH-1:0]     lockCounter
);

    localparam int AW = `SAMPLE_WIDTH + $clog2(`AVG_LENGTH);
    localparam int CW = $clog2(`AVG_LENGTH) + 1;
    localparam int LW = `LOCK_WIDTH;

    logic [AW-1:0] offSum;
    logic [AW-1:0] onSum;
    logic [CW-1:0] avgCount;
    logic [LW:0]   lockMinus;
    logic          eyeClosed;

    // Borrow out of bit LW marks the wrap below zero
    assign lockMinus = {1'b0, lockCounter} - 1'b1;
    assign eyeClosed = offSum[AW-1 -: 8] > {1'b0, onSum[AW-1 -: 7]};

    always_ff @(posedge sampleClk) begin
        if (reset) begin
            offSum      <= '0;
            onSum       <= '0;
            avgCount    <= CW'(`AVG_LENGTH);
            bitsyncLock <= 1'b0;
            lockCounter <= '0;
        end else if (errorValid) begin
            if (avgCount == '0) begin
                // Test the block, then start a new one
                offSum   <= '0;
                onSum    <= '0;
                avgCount <= CW'(`AVG_LENGTH);
                if (eyeClosed) begin
                    if (lockMinus[LW]) begin
                        bitsyncLock <= 1'b0;
                        lockCounter <= '0;
                    end else begin
                        lockCounter <= lockMinus[LW-1:0];
                    end
                end else if (lockCounter == LW'(lockCount)) begin
                    bitsyncLock <= 1'b1;
                    lockCounter <= '0;
                end else begin
                    lockCounter <= lockCounter + 1'b1;
                end
            end else if (ted.transition) begin
                offSum   <= offSum + AW'(ted.offMag);
                onSum    <= onSum + AW'(ted.onMag);
                avgCount <= avgCount - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/bitsync.sv */
// Dual-rail PSK symbol timing synchronizer, two samples per symbol
// Matched filter, crossing detector, loop filter, lock and APB control

`timescale 1ns/1ps
`default_nettype none

module bitsync (
    input  logic                    sampleClk,
    input  logic                    reset,
    input  logic                    symTimes2Sync,
    input  bitsyncPkg::apbRequest_t apb,
    input  bitsyncPkg::iqSample_t   rawIn,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic [31:0]             sampleFreq,
    output logic signed [17:0]      offsetError,
    output logic                    offsetErrorEn,
    output logic signed [17:0]      bsError,
    output logic                    bsErrorEn,
    output bitsyncPkg::iqSample_t   symData,
    output logic                    bitDataI,
    output logic                    bitDataQ,
    output logic                    iSymEn,
    output logic                    qSymEn,
    output logic                    sym2xEn,
    output logic                    bitsyncLock
);

    bitsyncPkg::bitsyncConfig_t cfg;
    bitsyncPkg::iqSample_t      mf;
    bitsyncPkg::timingError_t   ted;
    logic                       onTime;
    logic                       errorValid;
    logic [15:0]                lockCounter;

    bitsyncControl control (
        .sampleClk(sampleClk), .reset(reset), .apb(apb), .symTimes2Sync(symTimes2Sync),
        .bitsyncLock(bitsyncLock), .lockCounter(lockCounter),
        .prdata(prdata), .pready(pready), .cfg(cfg), .onTime(onTime)
    );

    matchedSummer summer (
        .sampleClk(sampleClk), .symTimes2Sync(symTimes2Sync), .cfg(cfg),
        .rawIn(rawIn), .mf(mf)
    );

    transitionDetector detector (
        .sampleClk(sampleClk), .reset(reset), .symTimes2Sync(symTimes2Sync),
        .onTime(onTime), .mf(mf), .ted(ted), .errorValid(errorValid),
        .offsetError(offsetError), .bsError(bsError), .symData(symData),
        .bitDataI(bitDataI), .bitDataQ(bitDataQ)
    );

    loopFilter sampleLoop (
        .sampleClk(sampleClk), .reset(reset), .errorValid(errorValid),
        .error(ted.error), .propShift(cfg.propShift), .intShift(cfg.intShift),
        .sampleFreq(sampleFreq)
    );

    lockDetector lock (
        .sampleClk(sampleClk), .reset(reset), .errorValid(errorValid), .ted(ted),
        .lockCount(cfg.lockCount), .bitsyncLock(bitsyncLock), .lockCounter(lockCounter)
    );

    // Symbol enables, both rails share one clock
    assign iSymEn        = symTimes2Sync & onTime;
    assign qSymEn        = symTimes2Sync & onTime;
    assign sym2xEn       = symTimes2Sync;
    assign offsetErrorEn = errorValid;
    assign bsErrorEn     = errorValid;

endmodule

`default_nettype wire

/* tb/sampleClock.sv */
// Testbench clock source, free running at a 40 ns period

`timescale 1ns/1ps
`default_nettype none

module sampleClock #(
    parameter int PERIOD = 40
) (
    output logic sampleClk
);

    initial begin
        sampleClk = 1'b0;
        forever #(PERIOD / 2) sampleClk = ~sampleClk;
    end

endmodule

`default_nettype wire

/* tb/bitsyncTb.sv */
// Testbench for the bit synchronizer
// Random samples checked against a reference model, APB register
// checks and lock acquisition on an ideal symbol stream

`timescale 1ns/1ps
`default_nettype none

`include "bitsync_config.svh"

module bitsyncTb;

    localparam int FLUSH_STROBES  = 6;
    localparam int RANDOM_STROBES = 200;
    localparam int LOCK_PAIRS     = 200;
    localparam int HOLD_PAIRS     = 40;
    // Four cycles per strobe plus a two-cycle STATUS read per lock symbol
    localparam int TEST_CYCLES = 4 * (FLUSH_STROBES + 2 * RANDOM_STROBES)
                               + 10 * (LOCK_PAIRS + HOLD_PAIRS) + 200;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;
    localparam logic signed [17:0] FULL_SCALE = 18'sd131071;

    logic                    sampleClk;
    logic                    reset;
    logic                    symTimes2Sync;
    bitsyncPkg::apbRequest_t apb;
    bitsyncPkg::iqSample_t   rawIn;
    logic [31:0]             prdata;
    logic                    pready;
    logic [31:0]             sampleFreq;
    logic signed [17:0]      offsetError;
    logic                    offsetErrorEn;
    logic signed [17:0]      bsError;
    logic                    bsErrorEn;
    bitsyncPkg::iqSample_t   symData;
    logic                    bitDataI;
    logic                    bitDataQ;
    logic                    iSymEn;
    logic                    qSymEn;
    logic                    sym2xEn;
    logic                    bitsyncLock;

    // Reference model state with I at index 0 and Q at index 1
    logic signed [17:0] mDel [2];
    logic signed [17:0] mMf [2];
    logic signed [17:0] mLate [2];
    logic signed [17:0] mOff [2];
    logic signed [17:0] mEarly [2];
    logic signed [17:0] mSym [2];
    logic signed [17:0] mSkew;
    logic signed [17:0] mBs;
    logic signed [17:0] mOffErr;
    int                 mInteg;
    int                 mFreq;
    logic               mOnTime;
    logic [31:0]        mCtrl;
    logic [31:0]        mGains;
    logic [31:0]        mLock;

    int                 seed;
    int                 errorCount;
    int                 strobeCount;
    int                 cycleCount = 0;
    logic signed [17:0] level;
    logic [31:0]        status;
    logic               locked;

    sampleClock clockGen (.sampleClk(sampleClk));

    bitsync DUT (
        .sampleClk(sampleClk), .reset(reset), .symTimes2Sync(symTimes2Sync),
        .apb(apb), .rawIn(rawIn), .prdata(prdata), .pready(pready),
        .sampleFreq(sampleFreq), .offsetError(offsetError), .offsetErrorEn(offsetErrorEn),
        .bsError(bsError), .bsErrorEn(bsErrorEn), .symData(symData),
        .bitDataI(bitDataI), .bitDataQ(bitDataQ), .iSymEn(iSymEn), .qSymEn(qSymEn),
        .sym2xEn(sym2xEn), .bitsyncLock(bitsyncLock)
    );

    always @(posedge sampleClk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic noteMismatch(input string what, input logic [63:0] got,
                                input logic [63:0] want);
        errorCount++;
        $display("Fail %0t: %s got %0h expected %0h", $time, what, got, want);
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (2) @(posedge sampleClk);
        #2;
        reset = 1'b0;
    endtask

    // **************************************************
    // APB access, zero wait states
    // **************************************************
    task automatic writeReg(input logic [3:0] addr, input logic [31:0] data);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(posedge sampleClk);
        #2;
        apb.penable = 1'b1;
        @(posedge sampleClk);
        #2;
        apb = '0;
        case (addr)
            `REG_CTRL:  mCtrl  = data & 32'h7;
            `REG_GAINS: mGains = data & 32'h1f1f;
            `REG_LOCK:  mLock  = data & 32'h7fff;
            default: ;
        endcase
    endtask

    task automatic apbRead(input logic [3:0] addr, output logic [31:0] data);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        @(posedge sampleClk);
        #2;
        apb.penable = 1'b1;
        #1;
        data = prdata;
        if (pready !== 1'b1) begin
            noteMismatch("pready during access", pready, 1'b1);
        end
        @(posedge sampleClk);
        #2;
        apb = '0;
    endtask

    task automatic expectRead(input logic [3:0] addr, input logic [31:0] want,
                              input string what);
        logic [31:0] data;
        apbRead(addr, data);
        if (data !== want) begin
            noteMismatch(what, data, want);
        end
    endtask

    // **************************************************
    // Reference model, one step per strobe
    // **************************************************
    task automatic modelReset();
        for (int r = 0; r < 2; r++) begin
            mDel[r]   = '0;
            mMf[r]    = '0;
            mLate[r]  = '0;
            mOff[r]   = '0;
            mEarly[r] = '0;
            mSym[r]   = '0;
        end
        mSkew   = '0;
        mOnTime = 1'b1;
        mInteg  = 0;
        mFreq   = 0;
        mCtrl   = 32'd0;
        mGains  = 32'd4;
        mLock   = 32'd3;
    endtask

    task automatic modelStep(input logic signed [17:0] inI, input logic signed [17:0] inQ);
        logic signed [17:0] in [2];
        logic signed [17:0] filt [2];
        logic signed [17:0] railErr [2];
        int                 e;
        in[0] = inI;
        in[1] = inQ;
        // Detector sees history and filter output from before the strobe
        if (mOnTime) begin
            mSym = mOff;
        end else begin
            for (int r = 0; r < 2; r++) begin
                if (mEarly[r][17] == mLate[r][17]) begin
                    railErr[r] = '0;
                end else if (mEarly[r][17]) begin
                    railErr[r] = mOff[r];
                end else begin
                    railErr[r] = -mOff[r];
                end
            end
            e       = int'(railErr[0]) + int'(railErr[1]);
            mBs     = 18'((e >>> 1) + (e & 1));
            mOffErr = (mEarly[0][17] != mLate[0][17]) ? mOff[0] : '0;
            mInteg  = mInteg + (e <<< mGains[12:8]);
            mFreq   = mInteg + (e <<< mGains[4:0]);
        end
        mEarly = mOff;
        mOff   = mLate;
        mLate  = mMf;
        for (int r = 0; r < 2; r++) begin
            if (mCtrl[0]) begin
                filt[r] = 18'((int'(mDel[r]) + int'(in[r])) >>> 1);
            end else begin
                filt[r] = mDel[r];
            end
        end
        mMf[0] = filt[0];
        case (mCtrl[2:1])
            2'd0:    mMf[1] = filt[0];
            2'd2:    mMf[1] = mSkew;
            default: mMf[1] = filt[1];
        endcase
        mSkew   = filt[1];
        mDel    = in;
        mOnTime = !mOnTime;
    endtask

    // Runs one strobe and its checks between drive points 2 ns after an edge
    task automatic strobe(input logic signed [17:0] inI, input logic signed [17:0] inQ);
        logic wasOn;
        wasOn         = mOnTime;
        rawIn.i       = inI;
        rawIn.q       = inQ;
        symTimes2Sync = 1'b1;
        strobeCount++;
        #1;
        if (iSymEn !== wasOn || qSymEn !== wasOn || sym2xEn !== 1'b1) begin
            noteMismatch("symbol enables", {iSymEn, qSymEn, sym2xEn}, {wasOn, wasOn, 1'b1});
        end
        @(posedge sampleClk);
        modelStep(inI, inQ);
        #1;
        if (bsErrorEn !== !wasOn || offsetErrorEn !== !wasOn) begin
            noteMismatch("error enables", {bsErrorEn, offsetErrorEn}, {!wasOn, !wasOn});
        end
        if (wasOn) begin
            if (symData.i !== mSym[0] || bitDataI !== mSym[0][17]) begin
                noteMismatch("symData.i and bitDataI", {symData.i, bitDataI},
                             {mSym[0], mSym[0][17]});
            end
            if (symData.q !== mSym[1] || bitDataQ !== mSym[1][17]) begin
                noteMismatch("symData.q and bitDataQ", {symData.q, bitDataQ},
                             {mSym[1], mSym[1][17]});
            end
        end else begin
            if (bsError !== mBs) begin
                noteMismatch("bsError", bsError, mBs);
            end
            if (offsetError !== mOffErr) begin
                noteMismatch("offsetError", offsetError, mOffErr);
            end
        end
        #1;
        symTimes2Sync = 1'b0;
        @(posedge sampleClk);
        #1;
        if (!wasOn && sampleFreq !== mFreq) begin
            noteMismatch("sampleFreq", sampleFreq, mFreq);
        end
        repeat (2) @(posedge sampleClk);
        #2;
    endtask

    // Full scale on time with alternating sign and zero at the crossing
    task automatic idealSymbol();
        repeat (2) begin
            if (mOnTime) begin
                strobe(level, level);
                level = -level;
            end else begin
                strobe('0, '0);
            end
        end
    endtask

    initial begin
        seed          = 63;
        errorCount    = 0;
        strobeCount   = 0;
        reset         = 1'b1;
        symTimes2Sync = 1'b0;
        apb           = '0;
        rawIn         = '0;
        level         = FULL_SCALE;
        locked        = 1'b0;
        applyReset();

        // Fill the unreset pipeline with zeros, then clear the loop state
        repeat (FLUSH_STROBES) begin
            symTimes2Sync = 1'b1;
            @(posedge sampleClk);
            #2;
            symTimes2Sync = 1'b0;
            repeat (3) @(posedge sampleClk);
            #2;
        end
        applyReset();
        modelReset();

        // APB registers
        expectRead(`REG_CTRL, 32'd0, "CTRL after reset");
        expectRead(`REG_GAINS, 32'd4, "GAINS after reset");
        expectRead(`REG_LOCK, 32'd3, "LOCK after reset");
        expectRead(`REG_STATUS, 32'd0, "STATUS after reset");
        repeat (4) begin
            for (int k = 0; k < 3; k++) begin
                writeReg(4'(4 * k), $random(seed));
            end
            expectRead(`REG_CTRL, mCtrl, "CTRL readback");
            expectRead(`REG_GAINS, mGains, "GAINS readback");
            expectRead(`REG_LOCK, mLock, "LOCK readback");
        end
        writeReg(`REG_STATUS, 32'hffff_ffff);
        expectRead(`REG_STATUS, 32'd0, "STATUS after write");

        // BPSK, summer off, random gains
        writeReg(`REG_CTRL, 32'd0);
        writeReg(`REG_GAINS, $random(seed));
        repeat (RANDOM_STROBES) begin
            strobe(18'($random(seed)), 18'($random(seed)));
        end

        // Summer on, OQPSK
        writeReg(`REG_CTRL, 32'h5);
        repeat (RANDOM_STROBES) begin
            strobe(18'($random(seed)), 18'($random(seed)));
        end

        // **************************************************
        // Lock on an ideal stream
        // **************************************************
        writeReg(`REG_CTRL, 32'd0);
        writeReg(`REG_LOCK, 32'd3);
        for (int p = 0; p < LOCK_PAIRS && !locked; p++) begin
            idealSymbol();
            apbRead(`REG_STATUS, status);
            locked = status[16];
        end
        if (!locked) begin
            errorCount++;
            $display("Lock was not reported in STATUS within %0d symbols", LOCK_PAIRS);
        end
        repeat (HOLD_PAIRS) begin
            idealSymbol();
            apbRead(`REG_STATUS, status);
            if (status[16] !== 1'b1 || bitsyncLock !== 1'b1) begin
                noteMismatch("STATUS lock flag and bitsyncLock held",
                             {status[16], bitsyncLock}, 2'b11);
            end
        end

        $display("Errors: %0d after %0d strobes", errorCount, strobeCount);
        if (errorCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+source
source/bitsyncPkg.sv
source/bitsyncControl.sv
source/matchedSummer.sv
source/transitionDetector.sv
source/loopFilter.sv
source/lockDetector.sv
source/bitsync.sv
tb/sampleClock.sv
tb/bitsyncTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bitsync testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module bitsyncTb -Mdir build/obj -o bitsyncSim
build/obj/bitsyncSim | tee build/sim.log

if grep -q "FAIL: see errors above" build/sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
